/* common/cpu_bus_settings.svh */
`ifndef CPU_BUS_SETTINGS_SVH
`define CPU_BUS_SETTINGS_SVH

// Bus widths
`define CPU_ADDR_W 16
`define BUS_ADDR_W 13
`define ROM_ADDR_W 15
`define DATA_W 8

// Master-only local addresses
`define ADDR_BACKCOLOR 16'h6008
`define ADDR_IRQ_ACK 16'h600C

// Read value where nothing answers
`define UNMAPPED_DATA 8'hFF

`endif

/* common/cpu_bus_pkg.sv */
`default_nettype none

package cpu_bus_pkg;

	// Target of a decoded shared-bus access
	typedef enum logic [2:0] {
		REG_NONE,
		REG_SCROLL0,
		REG_SCROLL1,
		REG_OBJECT,
		REG_LATCH0,
		REG_LATCH1,
		REG_BACKCOLOR
	} region_t;

	// Owner of the shared bus in the current slot
	typedef enum logic {
		SLOT_MASTER,
		SLOT_SUB
	} slot_t;

	// Per-access sequence inside a decoder
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ROM,
		ST_SHARED,
		ST_DONE
	} dec_state_t;

endpackage

`default_nettype wire

/* common/cpu_decode_if.sv */
`timescale 1ns/10ps
`include "cpu_bus_settings.svh"
`default_nettype none

interface cpu_decode_if
	import cpu_bus_pkg::*;
();

	// Request side, held stable by the decoder while req is high
	logic                   req;
	region_t                region;
	logic [`BUS_ADDR_W-1:0] addr;
	logic                   we;
	logic [`DATA_W-1:0]     wdata;

	// Completion side, ack is a single-cycle pulse
	logic [`DATA_W-1:0]     rdata;
	logic                   ack;

	modport decoder (
		output req,
		output region,
		output addr,
		output we,
		output wdata,
		input  rdata,
		input  ack
	);

	modport mux (
		input  req,
		input  region,
		input  addr,
		input  we,
		input  wdata,
		output rdata,
		output ack
	);

endinterface

`default_nettype wire

/* rtl/master_decoder.sv */
`timescale 1ns/10ps
`include "cpu_bus_settings.svh"
`default_nettype none

module master_decoder
	import cpu_bus_pkg::*;
(
	input  logic                   clk_6m,
	input  logic                   rst_n,
	input  logic                   vblank_n,
	input  logic                   cpu_req,
	input  logic                   cpu_we,
	input  logic [`CPU_ADDR_W-1:0] cpu_addr,
	input  logic [`DATA_W-1:0]     cpu_wdata,
	output logic                   cpu_done,
	output logic [`DATA_W-1:0]     cpu_rdata,
	output logic [`ROM_ADDR_W-1:0] rom_addr,
	output logic                   rom_ce,
	input  logic [`DATA_W-1:0]     rom_data,
	output logic                   irq_n,
	cpu_decode_if.decoder          bus
);

	dec_state_t             state_q;
	region_t                region_d;
	region_t                region_q;
	logic                   is_irq_ack;
	logic                   accept;
	logic [`ROM_ADDR_W-1:0] addr_q;
	logic                   we_q;
	logic [`DATA_W-1:0]     wdata_q;
	logic [`DATA_W-1:0]     rdata_q;
	logic                   vblank_q;
	logic                   irq_q;

	//////////////////////////////////////////////////////////////////////
	// Master address map
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		region_d = REG_NONE;
		is_irq_ack = 1'b0;
		case (cpu_addr[15:13])
			3'b000: region_d = REG_SCROLL0;
			3'b001: region_d = REG_SCROLL1;
			3'b010: region_d = REG_OBJECT;
			3'b011: begin
				// 0x6000-0x6007 split into two latches by A2
				if (cpu_addr[12:3] == '0)
					region_d = cpu_addr[2] ? REG_LATCH1 : REG_LATCH0;
				else if (cpu_addr == `ADDR_BACKCOLOR)
					region_d = REG_BACKCOLOR;
				else if (cpu_addr == `ADDR_IRQ_ACK)
					is_irq_ack = cpu_we;
			end
			default: region_d = REG_NONE;
		endcase
	end

	assign accept = (state_q == ST_IDLE) && cpu_req;

	//////////////////////////////////////////////////////////////////////
	// Access sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (cpu_req) begin
						// A15 selects program ROM
						if (cpu_addr[15])
							state_q <= ST_ROM;
						else if (region_d != REG_NONE)
							state_q <= ST_SHARED;
						else
							state_q <= ST_DONE;
					end
				end
				ST_ROM: state_q <= ST_DONE;
				ST_SHARED: begin
					if (bus.ack)
						state_q <= ST_DONE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_6m) begin
		if (accept) begin
			addr_q <= cpu_addr[`ROM_ADDR_W-1:0];
			we_q <= cpu_we;
			wdata_q <= cpu_wdata;
			region_q <= region_d;
			rdata_q <= `UNMAPPED_DATA;
		end
		if (state_q == ST_ROM)
			rdata_q <= rom_data;
		if (state_q == ST_SHARED && bus.ack)
			rdata_q <= bus.rdata;
	end

	// Vblank interrupt, cleared by a write to the acknowledge address
	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			vblank_q <= 1'b1;
			irq_q <= 1'b0;
		end else begin
			vblank_q <= vblank_n;
			if (vblank_q && !vblank_n)
				irq_q <= 1'b1;
			else if (accept && is_irq_ack)
				irq_q <= 1'b0;
		end
	end

	assign irq_n = !irq_q;

	assign cpu_done = (state_q == ST_DONE);
	assign cpu_rdata = rdata_q;
	assign rom_ce = (state_q == ST_ROM);
	assign rom_addr = addr_q;

	assign bus.req = (state_q == ST_SHARED);
	assign bus.region = region_q;
	assign bus.addr = addr_q[`BUS_ADDR_W-1:0];
	assign bus.we = we_q;
	assign bus.wdata = wdata_q;

endmodule

`default_nettype wire

/* rtl/sub_decoder.sv */
`timescale 1ns/10ps
`include "cpu_bus_settings.svh"
`default_nettype none

module sub_decoder
	import cpu_bus_pkg::*;
(
	input  logic                   clk_6m,
	input  logic                   rst_n,
	input  logic                   cpu_req,
	input  logic                   cpu_we,
	input  logic [`CPU_ADDR_W-1:0] cpu_addr,
	input  logic [`DATA_W-1:0]     cpu_wdata,
	output logic                   cpu_done,
	output logic [`DATA_W-1:0]     cpu_rdata,
	output logic [`ROM_ADDR_W-1:0] rom_addr,
	output logic                   rom_ce,
	input  logic [`DATA_W-1:0]     rom_data,
	cpu_decode_if.decoder          bus
);

	dec_state_t             state_q;
	region_t                region_d;
	region_t                region_q;
	logic                   accept;
	logic [`ROM_ADDR_W-1:0] addr_q;
	logic                   we_q;
	logic [`DATA_W-1:0]     wdata_q;
	logic [`DATA_W-1:0]     rdata_q;

	// Sub map has only the two latches above 0x6000
	always_comb begin
		case (cpu_addr[15:13])
			3'b000: region_d = REG_SCROLL0;
			3'b001: region_d = REG_SCROLL1;
			3'b010: region_d = REG_OBJECT;
			3'b011: begin
				if (cpu_addr[12:3] == '0)
					region_d = cpu_addr[2] ? REG_LATCH1 : REG_LATCH0;
				else
					region_d = REG_NONE;
			end
			default: region_d = REG_NONE;
		endcase
	end

	assign accept = (state_q == ST_IDLE) && cpu_req;

	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (cpu_req) begin
						if (cpu_addr[15])
							state_q <= ST_ROM;
						else if (region_d != REG_NONE)
							state_q <= ST_SHARED;
						else
							state_q <= ST_DONE;
					end
				end
				ST_ROM: state_q <= ST_DONE;
				ST_SHARED: begin
					if (bus.ack)
						state_q <= ST_DONE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// Request capture and read data return
	always_ff @(posedge clk_6m) begin
		if (accept) begin
			addr_q <= cpu_addr[`ROM_ADDR_W-1:0];
			we_q <= cpu_we;
			wdata_q <= cpu_wdata;
			region_q <= region_d;
			rdata_q <= `UNMAPPED_DATA;
		end
		if (state_q == ST_ROM)
			rdata_q <= rom_data;
		if (state_q == ST_SHARED && bus.ack)
			rdata_q <= bus.rdata;
	end

	assign cpu_done = (state_q == ST_DONE);
	assign cpu_rdata = rdata_q;
	assign rom_ce = (state_q == ST_ROM);
	assign rom_addr = addr_q;

	assign bus.req = (state_q == ST_SHARED);
	assign bus.region = region_q;
	assign bus.addr = addr_q[`BUS_ADDR_W-1:0];
	assign bus.we = we_q;
	assign bus.wdata = wdata_q;

endmodule

`default_nettype wire

/* rtl/bus_mux.sv */
`timescale 1ns/10ps
`include "cpu_bus_settings.svh"
`default_nettype none

module bus_mux
	import cpu_bus_pkg::*;
(
	input  logic                   clk_6m,
	input  logic                   rst_n,
	cpu_decode_if.mux              m_bus,
	cpu_decode_if.mux              s_bus,
	output logic [`BUS_ADDR_W-1:0] bus_addr,
	output logic [`DATA_W-1:0]     bus_wdata,
	input  logic [`DATA_W-1:0]     bus_rdata,
	output logic                   bus_we,
	output logic                   scroll0_n,
	output logic                   scroll1_n,
	output logic                   object_n,
	output logic                   latch0_n,
	output logic                   latch1_n,
	output logic                   backcolor_n
);

	logic [1:0]             phase_q;
	slot_t                  slot;
	logic                   slot_end;
	logic                   strobe_on;
	logic                   act_q;
	region_t                region_q;
	logic [`BUS_ADDR_W-1:0] addr_q;
	logic                   we_q;
	logic [`DATA_W-1:0]     wdata_q;
	logic                   m_ack_q;
	logic                   s_ack_q;
	logic [`DATA_W-1:0]     m_rdata_q;
	logic [`DATA_W-1:0]     s_rdata_q;

	//////////////////////////////////////////////////////////////////////
	// Slot timing
	//////////////////////////////////////////////////////////////////////

	// Phases 0-1 master, 2-3 sub
	assign slot = phase_q[1] ? SLOT_SUB : SLOT_MASTER;
	// Second phase of the current slot
	assign slot_end = phase_q[0];

	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			phase_q <= 2'd0;
			act_q <= 1'b0;
			m_ack_q <= 1'b0;
			s_ack_q <= 1'b0;
		end else begin
			phase_q <= phase_q + 2'd1;
			m_ack_q <= act_q && slot_end && (slot == SLOT_MASTER);
			s_ack_q <= act_q && slot_end && (slot == SLOT_SUB);
			// Take the next owner's pending request as its slot opens
			if (slot_end)
				act_q <= (slot == SLOT_MASTER) ? s_bus.req : m_bus.req;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Request capture and read data
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		if (slot_end && slot == SLOT_SUB) begin
			region_q <= m_bus.region;
			addr_q <= m_bus.addr;
			we_q <= m_bus.we;
			wdata_q <= m_bus.wdata;
			s_rdata_q <= bus_rdata;
		end
		if (slot_end && slot == SLOT_MASTER) begin
			region_q <= s_bus.region;
			addr_q <= s_bus.addr;
			we_q <= s_bus.we;
			wdata_q <= s_bus.wdata;
			m_rdata_q <= bus_rdata;
		end
	end

	assign m_bus.rdata = m_rdata_q;
	assign m_bus.ack = m_ack_q;
	assign s_bus.rdata = s_rdata_q;
	assign s_bus.ack = s_ack_q;

	// Address and data span the whole slot, strobe only its second phase
	assign bus_addr = addr_q;
	assign bus_wdata = wdata_q;
	assign bus_we = act_q && we_q;

	assign strobe_on = act_q && slot_end;

	assign scroll0_n = !(strobe_on && region_q == REG_SCROLL0);
	assign scroll1_n = !(strobe_on && region_q == REG_SCROLL1);
	assign object_n = !(strobe_on && region_q == REG_OBJECT);
	assign latch0_n = !(strobe_on && region_q == REG_LATCH0);
	assign latch1_n = !(strobe_on && region_q == REG_LATCH1);
	assign backcolor_n = !(strobe_on && region_q == REG_BACKCOLOR);

endmodule

`default_nettype wire

/* rtl/cpu_subsystem.sv */
`timescale 1ns/10ps
`include "cpu_bus_settings.svh"
`default_nettype none

module cpu_subsystem (
	input  logic                   clk_6m,
	input  logic                   rst_n,
	input  logic                   vblank_n,

	// Master CPU
	input  logic                   m_cpu_req,
	input  logic [`CPU_ADDR_W-1:0] m_cpu_addr,
	input  logic                   m_cpu_we,
	input  logic [`DATA_W-1:0]     m_cpu_wdata,
	output logic                   m_cpu_done,
	output logic [`DATA_W-1:0]     m_cpu_rdata,
	output logic                   m_irq_n,
	output logic [`ROM_ADDR_W-1:0] m_rom_addr,
	output logic                   m_rom_ce,
	input  logic [`DATA_W-1:0]     m_rom_data,

	// Sub CPU
	input  logic                   s_cpu_req,
	input  logic [`CPU_ADDR_W-1:0] s_cpu_addr,
	input  logic                   s_cpu_we,
	input  logic [`DATA_W-1:0]     s_cpu_wdata,
	output logic                   s_cpu_done,
	output logic [`DATA_W-1:0]     s_cpu_rdata,
	output logic [`ROM_ADDR_W-1:0] s_rom_addr,
	output logic                   s_rom_ce,
	input  logic [`DATA_W-1:0]     s_rom_data,

	// Shared video/latch bus
	output logic [`BUS_ADDR_W-1:0] bus_addr,
	output logic [`DATA_W-1:0]     bus_wdata,
	input  logic [`DATA_W-1:0]     bus_rdata,
	output logic                   bus_we,
	output logic                   scroll0_n,
	output logic                   scroll1_n,
	output logic                   object_n,
	output logic                   latch0_n,
	output logic                   latch1_n,
	output logic                   backcolor_n
);

	cpu_decode_if m_bus ();
	cpu_decode_if s_bus ();

	master_decoder i_master_decoder (
		.clk_6m    (clk_6m),
		.rst_n     (rst_n),
		.vblank_n  (vblank_n),
		.cpu_req   (m_cpu_req),
		.cpu_we    (m_cpu_we),
		.cpu_addr  (m_cpu_addr),
		.cpu_wdata (m_cpu_wdata),
		.cpu_done  (m_cpu_done),
		.cpu_rdata (m_cpu_rdata),
		.rom_addr  (m_rom_addr),
		.rom_ce    (m_rom_ce),
		.rom_data  (m_rom_data),
		.irq_n     (m_irq_n),
		.bus       (m_bus.decoder)
	);

	sub_decoder i_sub_decoder (
		.clk_6m    (clk_6m),
		.rst_n     (rst_n),
		.cpu_req   (s_cpu_req),
		.cpu_we    (s_cpu_we),
		.cpu_addr  (s_cpu_addr),
		.cpu_wdata (s_cpu_wdata),
		.cpu_done  (s_cpu_done),
		.cpu_rdata (s_cpu_rdata),
		.rom_addr  (s_rom_addr),
		.rom_ce    (s_rom_ce),
		.rom_data  (s_rom_data),
		.bus       (s_bus.decoder)
	);

	// Time-slot interleave of both decoders onto the shared bus
	bus_mux i_bus_mux (
		.clk_6m      (clk_6m),
		.rst_n       (rst_n),
		.m_bus       (m_bus.mux),
		.s_bus       (s_bus.mux),
		.bus_addr    (bus_addr),
		.bus_wdata   (bus_wdata),
		.bus_rdata   (bus_rdata),
		.bus_we      (bus_we),
		.scroll0_n   (scroll0_n),
		.scroll1_n   (scroll1_n),
		.object_n    (object_n),
		.latch0_n    (latch0_n),
		.latch1_n    (latch1_n),
		.backcolor_n (backcolor_n)
	);

endmodule

`default_nettype wire

/* dv/cpu_subsystem_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_subsystem_assert (
	input logic       clk_6m,
	input logic       rst_n,
	input logic [1:0] phase_q,
	input logic       bus_we,
	input logic       scroll0_n,
	input logic       scroll1_n,
	input logic       object_n,
	input logic       latch0_n,
	input logic       latch1_n,
	input logic       backcolor_n,
	input logic       m_ack_q,
	input logic       s_ack_q,
	input logic       m_req,
	input logic       s_req
);

	logic [5:0] strobes_n;
	logic       any_low;

	assign strobes_n = {scroll0_n, scroll1_n, object_n, latch0_n, latch1_n, backcolor_n};
	assign any_low = (strobes_n != 6'h3F);

	//////////////////////////////////////////////////////////////////////
	// Strobes
	//////////////////////////////////////////////////////////////////////

	one_strobe: assert property (@(posedge clk_6m) disable iff (!rst_n)
		$onehot0(~strobes_n))
		else $error("more than one shared-bus strobe low");

	// Write level spans the slot, the strobe its second phase
	we_first_phase: assert property (@(posedge clk_6m) disable iff (!rst_n)
		(bus_we && !phase_q[0]) |=> any_low)
		else $error("bus_we in first phase not followed by a strobe");

	we_second_phase: assert property (@(posedge clk_6m) disable iff (!rst_n)
		(bus_we && phase_q[0]) |-> any_low)
		else $error("bus_we high in second phase without a strobe");

	// Strobe only for a request still pending from the slot owner
	strobe_owner: assert property (@(posedge clk_6m) disable iff (!rst_n)
		any_low |-> (((phase_q == 2'd1) && m_req) || ((phase_q == 2'd3) && s_req)))
		else $error("strobe low without a pending request of the slot owner");

	// Only the master map reaches backcolor
	backcolor_owner: assert property (@(posedge clk_6m) disable iff (!rst_n)
		!backcolor_n |-> (phase_q == 2'd1))
		else $error("backcolor strobe outside the master slot");

	//////////////////////////////////////////////////////////////////////
	// Acknowledge pulses
	//////////////////////////////////////////////////////////////////////

	m_ack_pulse: assert property (@(posedge clk_6m) disable iff (!rst_n)
		m_ack_q |=> !m_ack_q)
		else $error("master ack longer than one cycle");

	s_ack_pulse: assert property (@(posedge clk_6m) disable iff (!rst_n)
		s_ack_q |=> !s_ack_q)
		else $error("sub ack longer than one cycle");

	m_ack_req: assert property (@(posedge clk_6m) disable iff (!rst_n)
		m_ack_q |-> m_req)
		else $error("master ack without a pending master request");

	s_ack_req: assert property (@(posedge clk_6m) disable iff (!rst_n)
		s_ack_q |-> s_req)
		else $error("sub ack without a pending sub request");

endmodule

bind bus_mux cpu_subsystem_assert i_cpu_subsystem_assert (
	.clk_6m      (clk_6m),
	.rst_n       (rst_n),
	.phase_q     (phase_q),
	.bus_we      (bus_we),
	.scroll0_n   (scroll0_n),
	.scroll1_n   (scroll1_n),
	.object_n    (object_n),
	.latch0_n    (latch0_n),
	.latch1_n    (latch1_n),
	.backcolor_n (backcolor_n),
	.m_ack_q     (m_ack_q),
	.s_ack_q     (s_ack_q),
	.m_req       (m_bus.req),
	.s_req       (s_bus.req)
);

`default_nettype wire

/* dv/cpu_subsystem_tb.sv */
`timescale 1ns/10ps
`include "cpu_bus_settings.svh"
`default_nettype none

module cpu_subsystem_tb
	import cpu_bus_pkg::*;
();

	localparam int ACCESS_TIMEOUT = 64;
	localparam int SOLO_COUNT = 40;
	localparam int DUAL_COUNT = 60;
	localparam logic CPU_M = 1'b0;
	localparam logic CPU_S = 1'b1;

	typedef struct packed {
		region_t                region;
		logic [`BUS_ADDR_W-1:0] addr;
		logic                   we;
		logic [`DATA_W-1:0]     data;
	} strobe_t;

	typedef struct packed {
		logic                   cpu;
		logic [`CPU_ADDR_W-1:0] addr;
		logic                   we;
		logic [`DATA_W-1:0]     wdata;
		logic [`DATA_W-1:0]     rdata;
		int                     cycles;
		int                     ce_count;
		logic                   rom_addr_ok;
		int                     n_strobe;
		strobe_t                strobe;
	} result_t;

	typedef struct packed {
		region_t            region;
		logic [`DATA_W-1:0] rdata;
		int                 cycles;
	} expect_t;

	logic                   clk_6m = 1'b0;
	logic                   rst_n;
	logic                   vblank_n;
	logic                   m_cpu_req;
	logic [`CPU_ADDR_W-1:0] m_cpu_addr;
	logic                   m_cpu_we;
	logic [`DATA_W-1:0]     m_cpu_wdata;
	logic                   m_cpu_done;
	logic [`DATA_W-1:0]     m_cpu_rdata;
	logic                   m_irq_n;
	logic [`ROM_ADDR_W-1:0] m_rom_addr;
	logic                   m_rom_ce;
	logic [`DATA_W-1:0]     m_rom_data;
	logic                   s_cpu_req;
	logic [`CPU_ADDR_W-1:0] s_cpu_addr;
	logic                   s_cpu_we;
	logic [`DATA_W-1:0]     s_cpu_wdata;
	logic                   s_cpu_done;
	logic [`DATA_W-1:0]     s_cpu_rdata;
	logic [`ROM_ADDR_W-1:0] s_rom_addr;
	logic                   s_rom_ce;
	logic [`DATA_W-1:0]     s_rom_data;
	logic [`BUS_ADDR_W-1:0] bus_addr;
	logic [`DATA_W-1:0]     bus_wdata;
	logic [`DATA_W-1:0]     bus_rdata;
	logic                   bus_we;
	logic                   scroll0_n;
	logic                   scroll1_n;
	logic                   object_n;
	logic                   latch0_n;
	logic                   latch1_n;
	logic                   backcolor_n;
	logic                   any_strobe;
	logic [1:0]             phase;

	integer    seed;
	strobe_t   m_log[$];
	strobe_t   s_log[$];
	int        m_log_rd = 0;
	int        s_log_rd = 0;
	result_t   results[$];
	int        check_rd = 0;
	int        issued = 0;
	int        check_errors = 0;
	int        direct_errors = 0;
	int        protocol_errors = 0;
	int        timeout_count = 0;
	bit        stalled = 1'b0;

	always #20 clk_6m = ~clk_6m;

	cpu_subsystem i_cpu_subsystem (.*);

	//////////////////////////////////////////////////////////////////////
	// ROM and shared memory models
	//////////////////////////////////////////////////////////////////////

	assign m_rom_data = m_rom_addr[7:0] ^ 8'hA5;
	assign s_rom_data = s_rom_addr[7:0] ^ 8'h3C;

	assign any_strobe = !(scroll0_n && scroll1_n && object_n && latch0_n && latch1_n
		&& backcolor_n);
	assign bus_rdata = any_strobe ? (bus_addr[7:0] ^ 8'h5A) : 8'h00;

	// Slot owner of each strobe, master in phases 0-1 and sub in 2-3
	always @(posedge clk_6m) begin
		if (!rst_n)
			phase <= 2'd0;
		else
			phase <= phase + 2'd1;
	end

	function automatic region_t strobe_region();
		region_t hit;
		hit = REG_NONE;
		if (!scroll0_n) hit = REG_SCROLL0;
		if (!scroll1_n) hit = REG_SCROLL1;
		if (!object_n) hit = REG_OBJECT;
		if (!latch0_n) hit = REG_LATCH0;
		if (!latch1_n) hit = REG_LATCH1;
		if (!backcolor_n) hit = REG_BACKCOLOR;
		return hit;
	endfunction

	always @(negedge clk_6m) begin : strobe_logger
		strobe_t entry;
		if (rst_n && any_strobe) begin
			entry.region = strobe_region();
			entry.addr = bus_addr;
			entry.we = bus_we;
			entry.data = bus_we ? bus_wdata : bus_rdata;
			if (phase[1])
				s_log.push_back(entry);
			else
				m_log.push_back(entry);
		end
	end

	always @(negedge clk_6m) begin
		if (rst_n && m_cpu_done && !m_cpu_req) begin
			$display("Error at %0t: master cpu_done without a request", $time);
			protocol_errors++;
		end
		if (rst_n && s_cpu_done && !s_cpu_req) begin
			$display("Error at %0t: sub cpu_done without a request", $time);
			protocol_errors++;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and checker
	//////////////////////////////////////////////////////////////////////

	function automatic string cpu_name(input logic cpu);
		return cpu ? "sub" : "master";
	endfunction

	function automatic void show_mismatch(input string msg);
		$display("Mismatch at %0t: %s", $time, msg);
	endfunction

	// cycles of 0 means a shared access of variable latency
	function automatic expect_t reference_access(input logic cpu,
		input logic [`CPU_ADDR_W-1:0] addr);
		expect_t e;
		e.region = REG_NONE;
		e.rdata = `UNMAPPED_DATA;
		e.cycles = 1;
		if (addr >= 16'h8000) begin
			e.rdata = addr[7:0] ^ (cpu ? 8'h3C : 8'hA5);
			e.cycles = 2;
		end else if (addr < 16'h2000)
			e.region = REG_SCROLL0;
		else if (addr < 16'h4000)
			e.region = REG_SCROLL1;
		else if (addr < 16'h6000)
			e.region = REG_OBJECT;
		else if (addr <= 16'h6003)
			e.region = REG_LATCH0;
		else if (addr <= 16'h6007)
			e.region = REG_LATCH1;
		else if (cpu == CPU_M && addr == `ADDR_BACKCOLOR)
			e.region = REG_BACKCOLOR;
		if (e.region != REG_NONE) begin
			e.rdata = addr[7:0] ^ 8'h5A;
			e.cycles = 0;
		end
		return e;
	endfunction

	always @(negedge clk_6m) begin : compare_results
		result_t r;
		expect_t e;
		strobe_t want;
		while (check_rd < results.size()) begin
			r = results[check_rd];
			check_rd++;
			e = reference_access(r.cpu, r.addr);
			if (!r.we && r.rdata !== e.rdata) begin
				show_mismatch($sformatf("%s read 0x%h returned 0x%h, expected 0x%h",
					cpu_name(r.cpu), r.addr, r.rdata, e.rdata));
				check_errors++;
			end
			if (e.cycles != 0 && r.cycles != e.cycles) begin
				show_mismatch($sformatf("%s access 0x%h done after %0d cycles, expected %0d",
					cpu_name(r.cpu), r.addr, r.cycles, e.cycles));
				check_errors++;
			end
			if (r.ce_count != (r.addr[15] ? 1 : 0) || !r.rom_addr_ok) begin
				show_mismatch($sformatf("%s access 0x%h rom_ce %0d cycles, address ok %0b",
					cpu_name(r.cpu), r.addr, r.ce_count, r.rom_addr_ok));
				check_errors++;
			end
			if (e.region == REG_NONE && r.n_strobe != 0) begin
				show_mismatch($sformatf("%s access 0x%h caused %0d strobes, expected none",
					cpu_name(r.cpu), r.addr, r.n_strobe));
				check_errors++;
			end
			if (e.region != REG_NONE) begin
				want.region = e.region;
				want.addr = r.addr[`BUS_ADDR_W-1:0];
				want.we = r.we;
				want.data = r.we ? r.wdata : e.rdata;
				if (r.n_strobe != 1 || r.strobe !== want) begin
					show_mismatch($sformatf("%s access 0x%h strobes %0d, got %h, expected %h",
						cpu_name(r.cpu), r.addr, r.n_strobe, r.strobe, want));
					check_errors++;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// CPU stimulus
	//////////////////////////////////////////////////////////////////////

	// Called 2 ns after a rising edge, returns at the same offset
	task automatic cpu_access(input logic cpu, input logic [`CPU_ADDR_W-1:0] addr,
		input logic we, input logic [`DATA_W-1:0] wdata);
		int      cycles;
		logic    done;
		result_t res;
		if (stalled)
			return;
		issued++;
		res = '0;
		res.cpu = cpu;
		res.addr = addr;
		res.we = we;
		res.wdata = wdata;
		res.rom_addr_ok = 1'b1;
		if (cpu) begin
			s_cpu_req = 1'b1;
			s_cpu_addr = addr;
			s_cpu_we = we;
			s_cpu_wdata = wdata;
		end else begin
			m_cpu_req = 1'b1;
			m_cpu_addr = addr;
			m_cpu_we = we;
			m_cpu_wdata = wdata;
		end
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < ACCESS_TIMEOUT) begin
			@(posedge clk_6m);
			#2;
			cycles++;
			if (cpu ? s_rom_ce : m_rom_ce) begin
				res.ce_count++;
				if ((cpu ? s_rom_addr : m_rom_addr) != addr[`ROM_ADDR_W-1:0])
					res.rom_addr_ok = 1'b0;
			end
			done = cpu ? s_cpu_done : m_cpu_done;
		end
		if (!done) begin
			$display("Timeout at %0t: %s access to 0x%h received no cpu_done",
				$time, cpu_name(cpu), addr);
			timeout_count++;
			stalled = 1'b1;
		end else begin
			res.cycles = cycles;
			res.rdata = cpu ? s_cpu_rdata : m_cpu_rdata;
			if (cpu) begin
				res.n_strobe = s_log.size() - s_log_rd;
				if (res.n_strobe > 0)
					res.strobe = s_log[s_log_rd];
				s_log_rd = s_log.size();
			end else begin
				res.n_strobe = m_log.size() - m_log_rd;
				if (res.n_strobe > 0)
					res.strobe = m_log[m_log_rd];
				m_log_rd = m_log.size();
			end
			results.push_back(res);
			@(posedge clk_6m);
			#2;
		end
		if (cpu)
			s_cpu_req = 1'b0;
		else
			m_cpu_req = 1'b0;
	endtask

	task automatic pick_shared_addr(input logic cpu, output logic [`CPU_ADDR_W-1:0] addr);
		logic [31:0] r;
		logic [2:0]  sel;
		r = $random(seed);
		sel = r[18:16];
		// Sub has no backcolor, so one region fewer
		if (sel >= (cpu ? 3'd5 : 3'd6))
			sel = sel - 3'd3;
		case (sel)
			3'd0: addr = {3'b000, r[12:0]};
			3'd1: addr = {3'b001, r[12:0]};
			3'd2: addr = {3'b010, r[12:0]};
			3'd3: addr = 16'h6000 + {14'd0, r[1:0]};
			3'd4: addr = 16'h6004 + {14'd0, r[1:0]};
			default: addr = `ADDR_BACKCOLOR;
		endcase
	endtask

	task automatic random_access(input logic cpu);
		logic [31:0]            r;
		logic [`CPU_ADDR_W-1:0] addr;
		r = $random(seed);
		case (r[1:0])
			2'd0: addr = {1'b1, r[30:16]};
			2'd3: addr = 16'h6010 + (r[31:16] & 16'h1FEF);
			default: pick_shared_addr(cpu, addr);
		endcase
		cpu_access(cpu, addr, r[4], r[15:8]);
	endtask

	task automatic check_idle(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_6m);
			#2;
			if (any_strobe || bus_we !== 1'b0 || m_irq_n !== 1'b1
				|| m_cpu_done !== 1'b0 || s_cpu_done !== 1'b0) begin
				show_mismatch($sformatf("idle bus after reset: strobe %0b we %0b irq_n %0b",
					any_strobe, bus_we, m_irq_n));
				direct_errors++;
			end
		end
	endtask

	task automatic wait_irq_level(input logic level);
		int n;
		n = 0;
		while (m_irq_n !== level && n < 8) begin
			@(posedge clk_6m);
			#2;
			n++;
		end
		if (m_irq_n !== level) begin
			$display("Timeout at %0t: m_irq_n never reached %0b", $time, level);
			timeout_count++;
			stalled = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : run_test
		logic [`CPU_ADDR_W-1:0] addr;
		logic [31:0]            r;
		int                     n;
		seed = 88894;
		rst_n = 1'b0;
		vblank_n = 1'b1;
		m_cpu_req = 1'b0;
		m_cpu_addr = '0;
		m_cpu_we = 1'b0;
		m_cpu_wdata = '0;
		s_cpu_req = 1'b0;
		s_cpu_addr = '0;
		s_cpu_we = 1'b0;
		s_cpu_wdata = '0;
		repeat (5) @(posedge clk_6m);
		#2;
		rst_n = 1'b1;
		check_idle(8);

		// Program ROM on both CPUs
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			cpu_access(CPU_M, {1'b1, r[14:0]}, 1'b0, 8'h00);
			cpu_access(CPU_S, {1'b1, r[30:16]}, 1'b0, 8'h00);
		end

		// Shared bus, one CPU at a time
		for (int i = 0; i < SOLO_COUNT; i++) begin
			r = $random(seed);
			pick_shared_addr(CPU_M, addr);
			cpu_access(CPU_M, addr, r[0], r[15:8]);
		end
		for (int i = 0; i < SOLO_COUNT; i++) begin
			r = $random(seed);
			pick_shared_addr(CPU_S, addr);
			cpu_access(CPU_S, addr, r[0], r[15:8]);
		end

		// Unmapped space and the master-only backcolor latch
		cpu_access(CPU_M, 16'h7123, 1'b0, 8'h00);
		cpu_access(CPU_S, 16'h6040, 1'b0, 8'h00);
		cpu_access(CPU_S, `ADDR_BACKCOLOR, 1'b0, 8'h00);
		cpu_access(CPU_S, `ADDR_BACKCOLOR, 1'b1, 8'h77);
		cpu_access(CPU_M, `ADDR_BACKCOLOR, 1'b1, 8'h99);
		cpu_access(CPU_M, `ADDR_BACKCOLOR, 1'b0, 8'h00);
		cpu_access(CPU_S, `ADDR_IRQ_ACK, 1'b0, 8'h00);

		// Vblank interrupt held until the master acknowledges
		vblank_n = 1'b0;
		wait_irq_level(1'b0);
		cpu_access(CPU_M, 16'h8123, 1'b0, 8'h00);
		cpu_access(CPU_M, 16'h2040, 1'b1, 8'h3E);
		cpu_access(CPU_S, `ADDR_IRQ_ACK, 1'b1, 8'h00);
		cpu_access(CPU_M, `ADDR_IRQ_ACK, 1'b0, 8'h00);
		vblank_n = 1'b1;
		cpu_access(CPU_S, 16'h6001, 1'b0, 8'h00);
		if (!stalled && m_irq_n !== 1'b0) begin
			show_mismatch("m_irq_n released before the master acknowledge");
			direct_errors++;
		end
		cpu_access(CPU_M, `ADDR_IRQ_ACK, 1'b1, 8'h00);
		if (!stalled && m_irq_n !== 1'b1) begin
			show_mismatch("m_irq_n still low after the master acknowledge");
			direct_errors++;
		end

		// Both CPUs at once
		fork
			for (int i = 0; i < DUAL_COUNT; i++)
				random_access(CPU_M);
			for (int i = 0; i < DUAL_COUNT; i++)
				random_access(CPU_S);
		join

		n = 0;
		while (check_rd < results.size() && n < 4) begin
			@(posedge clk_6m);
			#2;
			n++;
		end
		if (check_rd < results.size()) begin
			$display("Timeout at %0t: checker did not process all results", $time);
			timeout_count++;
		end
		if (check_rd != issued && timeout_count == 0) begin
			$display("Error: %0d accesses issued but %0d checked", issued, check_rd);
			direct_errors++;
		end
		if (m_log.size() != m_log_rd || s_log.size() != s_log_rd) begin
			$display("Error: shared-bus strobe seen with no access pending");
			direct_errors++;
		end

		$display("Checked %0d accesses: %0d mismatches, %0d protocol errors, %0d timeouts",
			check_rd, check_errors + direct_errors, protocol_errors, timeout_count);
		if (check_errors == 0 && direct_errors == 0 && protocol_errors == 0
			&& timeout_count == 0 && check_rd > 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/cpu_bus_pkg.sv
common/cpu_decode_if.sv
rtl/master_decoder.sv
rtl/sub_decoder.sv
rtl/bus_mux.sv
rtl/cpu_subsystem.sv
dv/cpu_subsystem_assert.sv
dv/cpu_subsystem_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := cpu_subsystem_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) common/cpu_bus_settings.svh

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
